/* vlog.f */
logic/mhq_pkg.sv
logic/mhq_lu.sv
logic/mhq_ex.sv
logic/mhq_fill.sv
logic/mhq.sv
sim/mhq_chk.sv
sim/mhq_tb.sv

/* Makefile */
# Verilator build and run of the MHQ testbench

SOURCES = $(wildcard logic/*.sv sim/*.sv)

.PHONY: all run clean

all: obj_dir/Vmhq_tb

obj_dir/Vmhq_tb: vlog.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module mhq_tb -f vlog.f

run: obj_dir/Vmhq_tb
	./obj_dir/Vmhq_tb | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* sim/mhq_tb.sv */
// MHQ testbench

`timescale 1ns/1ps

module mhq_tb
    import mhq_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 2000;

    logic       clk;
    logic       n_rst;
    logic       i_lookup_valid;
    logic       i_lookup_dc_hit;
    addr_t      i_lookup_addr;
    lsu_func_t  i_lookup_lsu_func;
    data_t      i_lookup_data;
    logic       i_lookup_we;
    logic       i_fill_ack;
    line_data_t i_fill_data;
    logic       o_full;
    logic       o_fill_req;
    line_addr_t o_fill_addr;
    logic       o_fill_valid;
    line_data_t o_fill_line;
    line_addr_t o_fill_line_addr;

    int         errors;
    int         checks;
    bit         mem_enable;
    logic       req_seen;
    line_addr_t exp_addr_q[$];
    line_data_t exp_line_q[$];
    line_addr_t req_addr_q[$];
    line_addr_t fill_addr_q[$];
    line_data_t fill_line_q[$];

    mhq #(.MHQ_DEPTH(4)) dut (
        .clk(clk), .n_rst(n_rst),
        .i_lookup_valid(i_lookup_valid), .i_lookup_dc_hit(i_lookup_dc_hit),
        .i_lookup_addr(i_lookup_addr), .i_lookup_lsu_func(i_lookup_lsu_func),
        .i_lookup_data(i_lookup_data), .i_lookup_we(i_lookup_we),
        .i_fill_ack(i_fill_ack), .i_fill_data(i_fill_data),
        .o_full(o_full), .o_fill_req(o_fill_req), .o_fill_addr(o_fill_addr),
        .o_fill_valid(o_fill_valid), .o_fill_line(o_fill_line),
        .o_fill_line_addr(o_fill_line_addr)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Every memory word mixes in the full line address
    function automatic line_data_t fill_pattern(input line_addr_t la);
        line_data_t line;
        for (int w = 0; w < 4; w++) begin
            line[w*32 +: 32] = {la, 4'(w)} ^ 32'h9e37_79b9;
        end
        return line;
    endfunction

    function automatic line_addr_t line_of(input addr_t addr);
        return addr[ADDR_WIDTH-1:DC_OFFSET_WIDTH];
    endfunction

    // Store bytes land at the byte offset with the low data byte first
    function automatic line_data_t apply_store(input line_data_t line, input addr_t addr,
                                               input lsu_func_t func, input data_t data);
        int nbytes;
        int off;
        nbytes = (func == LSU_FUNC_SB) ? 1 : (func == LSU_FUNC_SH) ? 2 :
                 (func == LSU_FUNC_SW) ? 4 : 0;
        off = int'(addr[DC_OFFSET_WIDTH-1:0]);
        for (int b = 0; b < nbytes; b++) begin
            line[(off + b)*8 +: 8] = data[b*8 +: 8];
        end
        return line;
    endfunction

    task automatic check_line(input string name, input line_data_t got, input line_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input line_addr_t got, input line_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic idle(input int n);
        i_lookup_valid = 1'b0;
        repeat (n) step();
    endtask

    task automatic lookup(input lsu_func_t func, input addr_t addr, input data_t data,
                          input logic hit);
        i_lookup_valid    = 1'b1;
        i_lookup_dc_hit   = hit;
        i_lookup_addr     = addr;
        i_lookup_lsu_func = func;
        i_lookup_data     = data;
        i_lookup_we       = (func == LSU_FUNC_SB) || (func == LSU_FUNC_SH) ||
                            (func == LSU_FUNC_SW);
        step();
    endtask

    task automatic expect_fill(input addr_t addr, input line_data_t line);
        exp_addr_q.push_back(line_of(addr));
        exp_line_q.push_back(line);
    endtask

    // Match returned lines and requests against the expected order
    task automatic compare_fills();
        int wait_cycles;
        line_addr_t exp_addr;
        while (exp_addr_q.size() > 0) begin
            wait_cycles = 0;
            while (fill_addr_q.size() == 0 && wait_cycles < 100) begin
                step();
                wait_cycles++;
            end
            if (fill_addr_q.size() == 0) begin
                errors++;
                $display("Timed out waiting for the fill of line %h", exp_addr_q[0]);
                exp_addr_q.delete();
                exp_line_q.delete();
            end else begin
                exp_addr = exp_addr_q.pop_front();
                check_addr("o_fill_line_addr", fill_addr_q.pop_front(), exp_addr);
                check_line("o_fill_line", fill_line_q.pop_front(), exp_line_q.pop_front());
                if (req_addr_q.size() == 0) begin
                    errors++;
                    $display("Line %h returned without a fill request", exp_addr);
                end else begin
                    check_addr("o_fill_addr", req_addr_q.pop_front(), exp_addr);
                end
            end
        end
        idle(10);
        if (req_addr_q.size() != 0 || fill_addr_q.size() != 0) begin
            errors++;
            $display("Unexpected fill request or returned line after the expected ones");
            req_addr_q.delete();
            fill_addr_q.delete();
            fill_line_q.delete();
        end
    endtask

    task automatic store_word_miss();
        addr_t addr;
        addr = 32'h0000_1238;
        mem_enable = 1'b1;
        expect_fill(addr, apply_store(fill_pattern(line_of(addr)), addr, LSU_FUNC_SW,
                                      32'hdead_beef));
        lookup(LSU_FUNC_SW, addr, 32'hdead_beef, 1'b0);
        i_lookup_valid = 1'b0;
        // Request rises three cycles after the lookup
        check_bit("o_fill_req", o_fill_req, 1'b0);
        step();
        check_bit("o_fill_req", o_fill_req, 1'b0);
        step();
        check_bit("o_fill_req", o_fill_req, 1'b1);
        compare_fills();
    endtask

    task automatic merge_by_bypass();
        addr_t      base;
        line_data_t line;
        base = 32'h0000_5a30;
        mem_enable = 1'b1;
        line = apply_store(fill_pattern(line_of(base)), base + 1, LSU_FUNC_SB, 32'h0000_00ab);
        line = apply_store(line, base + 6, LSU_FUNC_SH, 32'h0000_cdef);
        expect_fill(base, line);
        lookup(LSU_FUNC_SB, base + 1, 32'h0000_00ab, 1'b0);
        lookup(LSU_FUNC_SH, base + 6, 32'h0000_cdef, 1'b0);
        idle(1);
        compare_fills();
    endtask

    task automatic skip_hits_and_fills();
        mem_enable = 1'b1;
        lookup(LSU_FUNC_SW, 32'h0000_3000, 32'h1234_5678, 1'b1);
        lookup(LSU_FUNC_FILL, 32'h0000_3010, 32'h0, 1'b0);
        lookup(LSU_FUNC_LB, 32'h0000_3020, 32'h0, 1'b1);
        idle(8);
        check_bit("o_fill_req", o_fill_req, 1'b0);
        compare_fills();
    endtask

    task automatic fill_queue_to_full();
        addr_t addr;
        data_t data;
        mem_enable = 1'b0;
        for (int i = 0; i < 5; i++) begin
            addr = 32'h0002_0004 + 32'(i) * 32'h100;
            data = 32'h5a00_0000 | 32'(i);
            if (i < 4) begin
                expect_fill(addr, apply_store(fill_pattern(line_of(addr)), addr,
                                              LSU_FUNC_SW, data));
            end
            lookup(LSU_FUNC_SW, addr, data, 1'b0);
            if (i == 3) begin
                check_bit("o_full", o_full, 1'b0);
            end
            if (i == 4) begin
                check_bit("o_full", o_full, 1'b1);
            end
        end
        idle(6);
        check_bit("o_full", o_full, 1'b1);
        mem_enable = 1'b1;
        compare_fills();
        check_bit("o_full", o_full, 1'b0);
    endtask

    task automatic load_miss_line();
        mem_enable = 1'b1;
        expect_fill(32'h0000_7c04, fill_pattern(line_of(32'h0000_7c04)));
        lookup(LSU_FUNC_LW, 32'h0000_7c04, 32'h0, 1'b0);
        idle(1);
        compare_fills();
    endtask

    // Bursts of stores with memory held off, so no entry leaves mid burst
    task automatic random_store_bursts();
        addr_t     addr;
        data_t     data;
        lsu_func_t func;
        int        found;
        for (int burst = 0; burst < 3; burst++) begin
            mem_enable = 1'b0;
            for (int i = 0; i < 8; i++) begin
                addr = 32'h0001_2000 + 32'($urandom_range(5, 0)) * 32'h340;
                case ($urandom_range(2, 0))
                    0: begin
                        func = LSU_FUNC_SB;
                        addr[3:0] = 4'($urandom_range(15, 0));
                    end
                    1: begin
                        func = LSU_FUNC_SH;
                        addr[3:0] = {3'($urandom_range(7, 0)), 1'b0};
                    end
                    default: begin
                        func = LSU_FUNC_SW;
                        addr[3:0] = {2'($urandom_range(3, 0)), 2'b00};
                    end
                endcase
                data = $urandom();
                lookup(func, addr, data, 1'b0);
                // Registered full flag tells whether this lookup was taken
                if (!o_full) begin
                    found = -1;
                    foreach (exp_addr_q[k]) begin
                        if (exp_addr_q[k] == line_of(addr)) found = k;
                    end
                    if (found < 0) begin
                        expect_fill(addr, fill_pattern(line_of(addr)));
                        found = exp_addr_q.size() - 1;
                    end
                    exp_line_q[found] = apply_store(exp_line_q[found], addr, func, data);
                end
            end
            idle(2);
            mem_enable = 1'b1;
            compare_fills();
        end
    endtask

    // Memory answers each request after 1 to 4 cycles
    initial begin : memory_model
        int delay;
        i_fill_ack  = 1'b0;
        i_fill_data = '0;
        forever begin
            step();
            if (mem_enable && o_fill_req) begin
                delay = $urandom_range(4, 1);
                repeat (delay - 1) step();
                i_fill_ack  = 1'b1;
                i_fill_data = fill_pattern(o_fill_addr);
                step();
                i_fill_ack  = 1'b0;
            end
        end
    end

    // Outputs sampled on the falling edge
    initial begin : fill_monitor
        req_seen = 1'b0;
        forever begin
            @(negedge clk);
            if (o_fill_valid) begin
                fill_addr_q.push_back(o_fill_line_addr);
                fill_line_q.push_back(o_fill_line);
            end
            if (o_fill_req && !req_seen) req_addr_q.push_back(o_fill_addr);
            req_seen = o_fill_req;
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin : main
        void'($urandom(32'h5d95_3887));
        errors            = 0;
        checks            = 0;
        mem_enable        = 1'b0;
        n_rst             = 1'b0;
        i_lookup_valid    = 1'b0;
        i_lookup_dc_hit   = 1'b0;
        i_lookup_addr     = '0;
        i_lookup_lsu_func = LSU_FUNC_LB;
        i_lookup_data     = '0;
        i_lookup_we       = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        n_rst = 1'b1;
        step();
        store_word_miss();
        merge_by_bypass();
        skip_hits_and_fills();
        fill_queue_to_full();
        load_miss_line();
        random_store_bursts();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* sim/mhq_chk.sv */
// MHQ fill interface assertions

`timescale 1ns/1ps

module mhq_chk
    import mhq_pkg::*;
(
    input logic       clk,
    input logic       n_rst,
    input logic       i_fill_req,
    input line_addr_t i_fill_addr,
    input logic       i_fill_valid
);

    // One returned line per acknowledge
    fill_valid_pulse: assert property (
        @(posedge clk) disable iff (~n_rst) i_fill_valid |=> ~i_fill_valid
    ) else $error("o_fill_valid high for two cycles in a row");

    // Address holds for the whole request
    fill_addr_hold: assert property (
        @(posedge clk) disable iff (~n_rst) i_fill_req |=> (~i_fill_req || $stable(i_fill_addr))
    ) else $error("o_fill_addr changed while o_fill_req was high");

    fill_req_after_reset: assert property (
        @(posedge clk) $rose(n_rst) |=> ~i_fill_req
    ) else $error("o_fill_req high in the first cycle after reset");

endmodule

bind mhq mhq_chk u_chk (
    .clk(clk),
    .n_rst(n_rst),
    .i_fill_req(o_fill_req),
    .i_fill_addr(o_fill_addr),
    .i_fill_valid(o_fill_valid)
);

/* logic/mhq.sv */
// Miss handling queue top level

`timescale 1ns/1ps

module mhq
    import mhq_pkg::*;
#(
    parameter int MHQ_DEPTH = 4
) (
    input  logic        clk,
    input  logic        n_rst,

    input  logic        i_lookup_valid,
    input  logic        i_lookup_dc_hit,
    input  addr_t       i_lookup_addr,
    input  lsu_func_t   i_lookup_lsu_func,
    input  data_t       i_lookup_data,
    input  logic        i_lookup_we,

    input  logic        i_fill_ack,
    input  line_data_t  i_fill_data,

    output logic        o_full,
    output logic        o_fill_req,
    output line_addr_t  o_fill_addr,
    output logic        o_fill_valid,
    output line_data_t  o_fill_line,
    output line_addr_t  o_fill_line_addr
);

    localparam int TAG_WIDTH = $clog2(MHQ_DEPTH);

    // Lookup to ex
    logic                 lu_en;
    logic                 lu_we;
    dc_offset_t           lu_offset;
    data_t                lu_wr_data;
    byte_select_t         lu_byte_select;
    logic                 lu_match;
    logic [TAG_WIDTH-1:0] lu_tag;
    line_addr_t           lu_addr;

    // Entry array and pointers
    logic       [MHQ_DEPTH-1:0] entry_valid;
    line_addr_t [MHQ_DEPTH-1:0] entry_addr;
    line_data_t [MHQ_DEPTH-1:0] entry_data;
    line_mask_t [MHQ_DEPTH-1:0] entry_mask;
    logic [TAG_WIDTH:0]         tail_next;
    logic [TAG_WIDTH:0]         head_next;
    logic                       dequeue;

    // Ex bypass report
    logic                 ex_bypass_en;
    logic                 ex_bypass_we;
    logic                 ex_bypass_match;
    line_addr_t           ex_bypass_addr;
    logic [TAG_WIDTH-1:0] ex_bypass_tag;

    mhq_lu #(.MHQ_DEPTH(MHQ_DEPTH)) u_lu (
        .clk(clk), .n_rst(n_rst),
        .i_entry_valid(entry_valid), .i_entry_addr(entry_addr),
        .i_tail_next(tail_next), .i_head_next(head_next),
        .i_ex_bypass_en(ex_bypass_en), .i_ex_bypass_we(ex_bypass_we),
        .i_ex_bypass_match(ex_bypass_match), .i_ex_bypass_addr(ex_bypass_addr),
        .i_ex_bypass_tag(ex_bypass_tag),
        .i_lookup_valid(i_lookup_valid), .i_lookup_dc_hit(i_lookup_dc_hit),
        .i_lookup_addr(i_lookup_addr), .i_lookup_lsu_func(i_lookup_lsu_func),
        .i_lookup_data(i_lookup_data), .i_lookup_we(i_lookup_we),
        .o_lu_en(lu_en), .o_lu_we(lu_we), .o_lu_offset(lu_offset),
        .o_lu_wr_data(lu_wr_data), .o_lu_byte_select(lu_byte_select),
        .o_lu_match(lu_match), .o_lu_tag(lu_tag), .o_lu_addr(lu_addr),
        .o_full(o_full)
    );

    mhq_ex #(.MHQ_DEPTH(MHQ_DEPTH)) u_ex (
        .clk(clk), .n_rst(n_rst),
        .i_lu_en(lu_en), .i_lu_we(lu_we), .i_lu_offset(lu_offset),
        .i_lu_wr_data(lu_wr_data), .i_lu_byte_select(lu_byte_select),
        .i_lu_match(lu_match), .i_lu_tag(lu_tag), .i_lu_addr(lu_addr),
        .i_dequeue(dequeue),
        .o_entry_valid(entry_valid), .o_entry_addr(entry_addr),
        .o_entry_data(entry_data), .o_entry_mask(entry_mask),
        .o_tail_next(tail_next),
        .o_ex_bypass_en(ex_bypass_en), .o_ex_bypass_we(ex_bypass_we),
        .o_ex_bypass_match(ex_bypass_match), .o_ex_bypass_addr(ex_bypass_addr),
        .o_ex_bypass_tag(ex_bypass_tag)
    );

    mhq_fill #(.MHQ_DEPTH(MHQ_DEPTH)) u_fill (
        .clk(clk), .n_rst(n_rst),
        .i_entry_valid(entry_valid), .i_entry_addr(entry_addr),
        .i_entry_data(entry_data), .i_entry_mask(entry_mask),
        .i_fill_ack(i_fill_ack), .i_fill_data(i_fill_data),
        .o_head_next(head_next), .o_dequeue(dequeue),
        .o_fill_req(o_fill_req), .o_fill_addr(o_fill_addr),
        .o_fill_valid(o_fill_valid), .o_fill_line(o_fill_line),
        .o_fill_line_addr(o_fill_line_addr)
    );

endmodule

/* logic/mhq_fill.sv */
// MHQ fill stage

`timescale 1ns/1ps

module mhq_fill
    import mhq_pkg::*;
#(
    parameter int MHQ_DEPTH = 4
) (
    input  logic                          clk,
    input  logic                          n_rst,

    input  logic       [MHQ_DEPTH-1:0]    i_entry_valid,
    input  line_addr_t [MHQ_DEPTH-1:0]    i_entry_addr,
    input  line_data_t [MHQ_DEPTH-1:0]    i_entry_data,
    input  line_mask_t [MHQ_DEPTH-1:0]    i_entry_mask,

    // Memory response
    input  logic                          i_fill_ack,
    input  line_data_t                    i_fill_data,

    output logic [$clog2(MHQ_DEPTH):0]    o_head_next,
    output logic                          o_dequeue,
    output logic                          o_fill_req,
    output line_addr_t                    o_fill_addr,
    output logic                          o_fill_valid,
    output line_data_t                    o_fill_line,
    output line_addr_t                    o_fill_line_addr
);

    localparam int TAG_WIDTH = $clog2(MHQ_DEPTH);

    typedef enum logic {
        FILL_IDLE,
        FILL_WAIT
    } fill_state_t;

    fill_state_t          state;
    fill_state_t          state_next;
    logic [TAG_WIDTH:0]   head;
    logic [TAG_WIDTH-1:0] head_idx;
    line_data_t           fill_merged;

    assign head_idx    = head[TAG_WIDTH-1:0];
    assign o_dequeue   = (state == FILL_WAIT) && i_fill_ack;
    assign o_head_next = head + (TAG_WIDTH + 1)'(o_dequeue);
    assign o_fill_req  = (state == FILL_WAIT);

    always_comb begin
        state_next = state;
        case (state)
            FILL_IDLE: if (i_entry_valid[head_idx]) state_next = FILL_WAIT;
            FILL_WAIT: if (i_fill_ack) state_next = FILL_IDLE;
            default:   state_next = FILL_IDLE;
        endcase
    end

    // Store bytes take priority over memory data
    always_comb begin
        for (int b = 0; b < LINE_BYTES; b++) begin
            fill_merged[b*8 +: 8] = i_entry_mask[head_idx][b] ? i_entry_data[head_idx][b*8 +: 8]
                                                              : i_fill_data[b*8 +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (~n_rst) begin
            state        <= FILL_IDLE;
            head         <= '0;
            o_fill_valid <= 1'b0;
        end else begin
            state        <= state_next;
            head         <= o_head_next;
            o_fill_valid <= o_dequeue;
        end
    end

    // Address is latched while idle so it holds through the request
    always_ff @(posedge clk) begin
        if (state == FILL_IDLE) o_fill_addr <= i_entry_addr[head_idx];
        if (o_dequeue) begin
            o_fill_line      <= fill_merged;
            o_fill_line_addr <= o_fill_addr;
        end
    end

endmodule

/* logic/mhq_ex.sv */
// MHQ execute stage
// Entry allocation and store merge

`timescale 1ns/1ps

module mhq_ex
    import mhq_pkg::*;
#(
    parameter int MHQ_DEPTH = 4
) (
    input  logic                          clk,
    input  logic                          n_rst,

    // Registered operation from the lookup stage
    input  logic                          i_lu_en,
    input  logic                          i_lu_we,
    input  dc_offset_t                    i_lu_offset,
    input  data_t                         i_lu_wr_data,
    input  byte_select_t                  i_lu_byte_select,
    input  logic                          i_lu_match,
    input  logic [$clog2(MHQ_DEPTH)-1:0]  i_lu_tag,
    input  line_addr_t                    i_lu_addr,

    // Head entry leaves the queue
    input  logic                          i_dequeue,

    output logic       [MHQ_DEPTH-1:0]    o_entry_valid,
    output line_addr_t [MHQ_DEPTH-1:0]    o_entry_addr,
    output line_data_t [MHQ_DEPTH-1:0]    o_entry_data,
    output line_mask_t [MHQ_DEPTH-1:0]    o_entry_mask,
    output logic [$clog2(MHQ_DEPTH):0]    o_tail_next,

    output logic                          o_ex_bypass_en,
    output logic                          o_ex_bypass_we,
    output logic                          o_ex_bypass_match,
    output line_addr_t                    o_ex_bypass_addr,
    output logic [$clog2(MHQ_DEPTH)-1:0]  o_ex_bypass_tag
);

    localparam int TAG_WIDTH = $clog2(MHQ_DEPTH);

    logic [TAG_WIDTH:0]   tail;
    logic [TAG_WIDTH-1:0] head;
    logic                 allocate;
    line_mask_t           wr_mask;
    line_data_t           wr_data;

    assign allocate = i_lu_en && ~i_lu_match;

    // Place the store lanes at their byte offset within the line
    assign wr_mask = i_lu_we ? (line_mask_t'(i_lu_byte_select) << i_lu_offset) : '0;
    assign wr_data = line_data_t'(i_lu_wr_data) << {i_lu_offset, 3'b000};

    assign o_tail_next = tail + (TAG_WIDTH + 1)'(allocate);

    always_ff @(posedge clk) begin
        if (~n_rst) begin
            tail <= '0;
        end else begin
            tail <= o_tail_next;
        end
    end

    // Local copy of the head slot that advances on every dequeue
    always_ff @(posedge clk) begin
        if (~n_rst) begin
            head <= '0;
        end else if (i_dequeue) begin
            head <= head + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (~n_rst) begin
            o_entry_valid <= '0;
        end else begin
            if (allocate) begin
                o_entry_valid[i_lu_tag] <= 1'b1;
            end
            // Dequeue wins over an allocation into the same slot
            if (i_dequeue) begin
                o_entry_valid[head] <= 1'b0;
            end
        end
    end

    // Line address, data and written-byte flags
    always_ff @(posedge clk) begin
        if (i_lu_en) begin
            if (allocate) begin
                o_entry_addr[i_lu_tag] <= i_lu_addr;
                o_entry_mask[i_lu_tag] <= wr_mask;
            end else begin
                o_entry_mask[i_lu_tag] <= o_entry_mask[i_lu_tag] | wr_mask;
            end
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (wr_mask[b]) begin
                    o_entry_data[i_lu_tag][b*8 +: 8] <= wr_data[b*8 +: 8];
                end
            end
        end
    end

    // Report the operation in flight so lookups see it early
    assign o_ex_bypass_en    = i_lu_en;
    assign o_ex_bypass_we    = i_lu_we;
    assign o_ex_bypass_match = i_lu_match;
    assign o_ex_bypass_addr  = i_lu_addr;
    assign o_ex_bypass_tag   = i_lu_tag;

endmodule

/* logic/mhq_lu.sv */
// MHQ lookup stage

`timescale 1ns/1ps

module mhq_lu
    import mhq_pkg::*;
#(
    parameter int MHQ_DEPTH = 4
) (
    input  logic                          clk,
    input  logic                          n_rst,

    // Entry state and pointers from the later stages
    input  logic       [MHQ_DEPTH-1:0]    i_entry_valid,
    input  line_addr_t [MHQ_DEPTH-1:0]    i_entry_addr,
    input  logic [$clog2(MHQ_DEPTH):0]    i_tail_next,
    input  logic [$clog2(MHQ_DEPTH):0]    i_head_next,

    // Operation currently in the ex stage
    input  logic                          i_ex_bypass_en,
    input  logic                          i_ex_bypass_we,
    input  logic                          i_ex_bypass_match,
    input  line_addr_t                    i_ex_bypass_addr,
    input  logic [$clog2(MHQ_DEPTH)-1:0]  i_ex_bypass_tag,

    // Lookup lane
    input  logic                          i_lookup_valid,
    input  logic                          i_lookup_dc_hit,
    input  addr_t                         i_lookup_addr,
    input  lsu_func_t                     i_lookup_lsu_func,
    input  data_t                         i_lookup_data,
    input  logic                          i_lookup_we,

    output logic                          o_lu_en,
    output logic                          o_lu_we,
    output dc_offset_t                    o_lu_offset,
    output data_t                         o_lu_wr_data,
    output byte_select_t                  o_lu_byte_select,
    output logic                          o_lu_match,
    output logic [$clog2(MHQ_DEPTH)-1:0]  o_lu_tag,
    output line_addr_t                    o_lu_addr,
    output logic                          o_full
);

    localparam int TAG_WIDTH = $clog2(MHQ_DEPTH);

    logic                 full_next;
    logic                 lookup_en;
    line_addr_t           lookup_addr;
    dc_offset_t           lookup_offset;
    byte_select_t         lookup_byte_select;
    logic                 bypass_hit;
    logic                 entry_hit;
    logic [TAG_WIDTH-1:0] entry_tag;
    logic [TAG_WIDTH-1:0] lookup_tag;

    // Same slot, opposite wrap bit means every entry is taken
    assign full_next = ({~i_tail_next[TAG_WIDTH], i_tail_next[TAG_WIDTH-1:0]} == i_head_next);

    assign lookup_addr   = i_lookup_addr[ADDR_WIDTH-1:DC_OFFSET_WIDTH];
    assign lookup_offset = i_lookup_addr[DC_OFFSET_WIDTH-1:0];

    assign lookup_en = i_lookup_valid && (i_lookup_lsu_func != LSU_FUNC_FILL) &&
                       ~i_lookup_dc_hit && ~full_next;

    // Ex changes an entry only when it allocates or writes store bytes
    assign bypass_hit = i_ex_bypass_en && (~i_ex_bypass_match || i_ex_bypass_we) &&
                        (i_ex_bypass_addr == lookup_addr);

    // First valid entry holding the same line
    always_comb begin
        entry_hit = 1'b0;
        entry_tag = '0;
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            if (!entry_hit && i_entry_valid[i] && (i_entry_addr[i] == lookup_addr)) begin
                entry_hit = 1'b1;
                entry_tag = TAG_WIDTH'(i);
            end
        end
    end

    // Bypass first, then a stored entry, else a new entry at the tail
    always_comb begin
        if (bypass_hit) begin
            lookup_tag = i_ex_bypass_tag;
        end else if (entry_hit) begin
            lookup_tag = entry_tag;
        end else begin
            lookup_tag = i_tail_next[TAG_WIDTH-1:0];
        end
    end

    always_comb begin
        case (i_lookup_lsu_func)
            LSU_FUNC_SB: lookup_byte_select = byte_select_t'(1);
            LSU_FUNC_SH: lookup_byte_select = byte_select_t'(3);
            LSU_FUNC_SW: lookup_byte_select = byte_select_t'(15);
            default:     lookup_byte_select = byte_select_t'(0);
        endcase
    end

    always_ff @(posedge clk) begin
        if (~n_rst) begin
            o_lu_en <= 1'b0;
            o_full  <= 1'b0;
        end else begin
            o_lu_en <= lookup_en;
            o_full  <= full_next;
        end
    end

    // Payload to ex
    always_ff @(posedge clk) begin
        o_lu_we          <= i_lookup_we;
        o_lu_offset      <= lookup_offset;
        o_lu_wr_data     <= i_lookup_data;
        o_lu_byte_select <= lookup_byte_select;
        o_lu_match       <= i_lookup_valid && (entry_hit || bypass_hit);
        o_lu_tag         <= lookup_tag;
        o_lu_addr        <= lookup_addr;
    end

endmodule

/* logic/mhq_pkg.sv */
// Miss handling queue types

package mhq_pkg;

    // Widths
    localparam int ADDR_WIDTH        = 32;
    localparam int DATA_WIDTH        = 32;
    localparam int DC_OFFSET_WIDTH   = 4;

    // Derived line geometry of 16 bytes per line
    localparam int LINE_BYTES        = 1 << DC_OFFSET_WIDTH;
    localparam int LINE_WIDTH        = LINE_BYTES * 8;
    localparam int LINE_ADDR_WIDTH   = ADDR_WIDTH - DC_OFFSET_WIDTH;
    localparam int BYTE_SELECT_WIDTH = DATA_WIDTH / 8;

    typedef logic [ADDR_WIDTH-1:0]        addr_t;
    typedef logic [DATA_WIDTH-1:0]        data_t;
    typedef logic [LINE_ADDR_WIDTH-1:0]   line_addr_t;
    typedef logic [DC_OFFSET_WIDTH-1:0]   dc_offset_t;
    typedef logic [LINE_WIDTH-1:0]        line_data_t;
    typedef logic [LINE_BYTES-1:0]        line_mask_t;
    typedef logic [BYTE_SELECT_WIDTH-1:0] byte_select_t;

    // Load/store unit operations seen by the queue
    typedef enum logic [2:0] {
        LSU_FUNC_LB   = 3'd0,
        LSU_FUNC_LH   = 3'd1,
        LSU_FUNC_LW   = 3'd2,
        LSU_FUNC_SB   = 3'd3,
        LSU_FUNC_SH   = 3'd4,
        LSU_FUNC_SW   = 3'd5,
        LSU_FUNC_FILL = 3'd6
    } lsu_func_t;

endpackage
